/* run.sh */
#!/bin/sh
# Build the burst memory testbench with Verilator and run it into sim.log
verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
    --top-module tb_burst_mem -f src.f || exit 1
./obj_dir/Vtb_burst_mem > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0

/* src.f */
+incdir+tb
verilog/mem_geom_pkg.sv
verilog/burst_pkg.sv
verilog/burst_if.sv
verilog/burst_cmd_decode.sv
verilog/burst_sequencer.sv
verilog/burst_mem_array.sv
verilog/burst_mem_top.sv
tb/tb_burst_mem.sv

/* tb/burst_mem_model.svh */
`ifndef BURST_MEM_MODEL_SVH
`define BURST_MEM_MODEL_SVH

// Expected memory contents, keys never written read as zero
word_t model_mem [int];

// Word address of beat k, wrapping at the top of memory
function automatic int wrap_addr(input int base, input int k);
    return (base + k) % MEM_WORDS;
endfunction

function automatic word_t model_read(input int a);
    if (model_mem.exists(a)) begin
        return model_mem[a];
    end
    return '0;
endfunction

// Only lanes with their enable bit set take the new byte
function automatic void model_write(input int a, input word_t data, input be_t mask);
    word_t w;
    w = model_read(a);
    for (int i = 0; i < LANES; i++) begin
        if (mask[i]) begin
            w[i*LANE_W +: LANE_W] = data[i*LANE_W +: LANE_W];
        end
    end
    model_mem[a] = w;
endfunction

function automatic word_t rand_word();
    return {$urandom, $urandom};
endfunction

function automatic be_t rand_mask();
    return be_t'($urandom);
endfunction

function automatic addr_t rand_addr();
    return addr_t'($urandom % MEM_WORDS);
endfunction

// Lengths 1 to MAX_LEN, never zero
function automatic len_t rand_len();
    return len_t'(1 + $urandom % MAX_LEN);
endfunction

`endif

/* tb/tb_burst_mem.sv */
`timescale 1ns/1ps

module tb_burst_mem;
    import mem_geom_pkg::*;
    import burst_pkg::*;

    localparam int MAX_LEN = 16;
    localparam int WAIT_LIMIT = 100;  // Cycles per wait loop

    logic  clk;
    logic  arst_n;
    logic  rd;
    logic  we;
    len_t  burstcnt;
    addr_t addr;
    word_t din;
    be_t   be;
    logic  busy;
    word_t dout;
    logic  dout_ready;

    int errors = 0;
    int timeouts = 0;

    `include "burst_mem_model.svh"

    burst_mem_top UUT (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .rd         ( rd         ),
        .we         ( we         ),
        .burstcnt   ( burstcnt   ),
        .addr       ( addr       ),
        .din        ( din        ),
        .be         ( be         ),
        .busy       ( busy       ),
        .dout       ( dout       ),
        .dout_ready ( dout_ready )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_and_finish();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic wait_idle();
        int cyc;
        cyc = 0;
        while (busy && cyc < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (busy) begin
            timeouts++;
            $display("Timeout at %0t: busy did not fall within %0d cycles", $time, WAIT_LIMIT);
        end
    endtask

    // Strobes are held for one edge only, busy sampled just after it
    task automatic issue_cmd(input logic r, input logic w, input len_t n, input addr_t a,
                             output logic busy_after);
        @(posedge clk);
        #2;
        rd       = r;
        we       = w;
        burstcnt = n;
        addr     = a;
        @(posedge clk);  // Accepting edge
        #1;
        busy_after = busy;
        #1;
        rd       = 1'b0;
        we       = 1'b0;
        burstcnt = '0;
    endtask

    task automatic write_burst(input addr_t a, input len_t n);
        logic b;
        issue_cmd(1'b0, 1'b1, n, a, b);
        check_bit("busy", 1'b1, b);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            #2;
            din = rand_word();
            be  = rand_mask();
            model_write(wrap_addr(a, k), din, be);  // Written on the next edge
        end
        wait_idle();
    endtask

    // Checks data against the model and each beat's cycle after the accepting edge
    task automatic read_burst(input addr_t a, input len_t n, input logic with_we);
        logic b;
        logic done;
        int   cyc;
        int   beats;
        issue_cmd(1'b1, with_we, n, a, b);
        check_bit("busy", 1'b1, b);
        cyc   = 0;
        beats = 0;
        done  = 1'b0;
        while (!done && cyc < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cyc++;
            if (dout_ready) begin
                if (cyc != READ_LATENCY + beats) begin
                    errors++;
                    $display("ERROR at %0t: dout_ready beat %0d expected at cycle %0d, got %0d",
                             $time, beats, READ_LATENCY + beats, cyc);
                end
                check_word("dout", model_read(wrap_addr(a, beats)), dout);
                beats++;
            end else if (!busy) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            timeouts++;
            $display("Timeout at %0t: read burst did not finish within %0d cycles",
                     $time, WAIT_LIMIT);
        end else if (beats != n) begin
            errors++;
            $display("ERROR at %0t: dout_ready beat count expected %0d, got %0d",
                     $time, n, beats);
        end
    endtask

    initial begin
        logic  b;
        addr_t a;
        len_t  n;
        void'($urandom(32'h150e_5339));
        arst_n   = 1'b0;
        rd       = 1'b0;
        we       = 1'b0;
        burstcnt = '0;
        addr     = '0;
        din      = '0;
        be       = '0;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Idle after reset, untouched memory reads zero
        check_bit("busy", 1'b0, busy);
        check_bit("dout_ready", 1'b0, dout_ready);
        read_burst(rand_addr(), len_t'(4), 1'b0);

        // Second pass over the same range exercises the lane merge
        repeat (12) begin
            a = rand_addr();
            n = rand_len();
            write_burst(a, n);
            write_burst(a, n);
            read_burst(a, n, 1'b0);
        end
        read_burst(rand_addr(), len_t'(MAX_LEN), 1'b0);

        // Writes while a long read runs are dropped
        a = rand_addr();
        n = len_t'(4);
        issue_cmd(1'b1, 1'b0, len_t'(MAX_LEN), rand_addr(), b);
        check_bit("busy", 1'b1, b);
        din = rand_word();
        be  = '1;
        repeat (3) begin
            issue_cmd(1'b0, 1'b1, n, a, b);
            check_bit("busy", 1'b1, b);
        end
        wait_idle();
        issue_cmd(1'b0, 1'b1, '0, a, b);  // Zero length
        check_bit("busy", 1'b0, b);
        read_burst(a, n, 1'b0);

        // Both strobes together act as a read
        a   = rand_addr();
        din = rand_word();
        be  = '1;
        read_burst(a, len_t'(4), 1'b1);
        read_burst(a, len_t'(4), 1'b0);

        // Burst across the top of memory
        write_burst(addr_t'(MEM_WORDS - 3), len_t'(8));
        read_burst(addr_t'(MEM_WORDS - 3), len_t'(8), 1'b0);
        read_burst('0, len_t'(5), 1'b0);

        report_and_finish();
    end

endmodule

/* verilog/burst_cmd_decode.sv */
`timescale 1ns/1ps

module burst_cmd_decode (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rd,
    input  logic                we,
    input  burst_pkg::len_t     burstcnt,
    input  mem_geom_pkg::addr_t addr,
    output logic                busy,
    burst_cmd_if.decoder        cmd
);

    logic accept;

    // Commands during a pending start or a running burst are dropped,
    // as are zero-length ones
    assign accept = (rd || we) && (burstcnt != '0) && !cmd.start && !cmd.active;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd.start <= 1'b0;
        end else begin
            cmd.start <= accept;  // Single pulse, accept is blocked next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.is_read <= rd;  // Read wins when both strobes are up
            cmd.len     <= burstcnt;
            cmd.base    <= addr;
        end
    end

    // Covers the gap before the sequencer raises active
    assign busy = cmd.start || cmd.active;

    // A new burst may only be handed over once the sequencer is idle
    a_start_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(cmd.start) |-> !cmd.active
    );

endmodule

/* verilog/burst_if.sv */
`timescale 1ns/1ps

// Command hand-off from decode to the sequencer
interface burst_cmd_if;
    import mem_geom_pkg::*;
    import burst_pkg::*;

    logic  start;    // One-cycle pulse
    logic  is_read;
    len_t  len;
    addr_t base;
    logic  active;   // Burst in progress

    // Decode holds start off while a burst runs
    modport decoder (
        output start,
        output is_read,
        output len,
        output base,
        input  active
    );

    modport sequencer (
        input  start,
        input  is_read,
        input  len,
        input  base,
        output active
    );
endinterface

// One access per cycle into the storage array
interface mem_port_if;
    import mem_geom_pkg::*;

    logic  wr;
    logic  rd;
    addr_t addr;
    word_t wdata;
    be_t   be;

    modport requester (
        output wr,
        output rd,
        output addr,
        output wdata,
        output be
    );

    modport storage (
        input wr,
        input rd,
        input addr,
        input wdata,
        input be
    );
endinterface

/* verilog/burst_mem_array.sv */
`timescale 1ns/1ps

module burst_mem_array (
    input  logic                clk,
    input  logic                arst_n,
    mem_port_if.storage         port,
    output mem_geom_pkg::word_t dout,
    output logic                dout_ready
);
    import mem_geom_pkg::*;

    word_t mem [MEM_WORDS];

    // Contents start cleared, reset leaves them alone
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Byte-lane write
    always @(posedge clk) begin
        if (port.wr) begin
            for (int i = 0; i < LANES; i++) begin
                if (port.be[i]) begin
                    mem[port.addr][i*LANE_W +: LANE_W] <= port.wdata[i*LANE_W +: LANE_W];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (port.rd) begin
            dout <= mem[port.addr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout_ready <= 1'b0;
        end else begin
            dout_ready <= port.rd;  // Valid for one cycle per read beat
        end
    end

    // The storage port takes a read or a write in a cycle, never both
    a_one_access: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(port.rd && port.wr)
    );

endmodule

/* verilog/burst_mem_top.sv */
`timescale 1ns/1ps

module burst_mem_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rd,
    input  logic                we,
    input  burst_pkg::len_t     burstcnt,
    input  mem_geom_pkg::addr_t addr,
    input  mem_geom_pkg::word_t din,
    input  mem_geom_pkg::be_t   be,
    output logic                busy,
    output mem_geom_pkg::word_t dout,
    output logic                dout_ready
);

    burst_cmd_if cmd ();
    mem_port_if  port ();

    // Command qualification and busy level
    burst_cmd_decode u_decode (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .rd       ( rd       ),
        .we       ( we       ),
        .burstcnt ( burstcnt ),
        .addr     ( addr     ),
        .busy     ( busy     ),
        .cmd      ( cmd      )
    );

    burst_sequencer u_sequencer (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .din    ( din    ),
        .be     ( be     ),
        .cmd    ( cmd    ),
        .port   ( port   )
    );

    // Storage with registered read port
    burst_mem_array u_array (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .port       ( port       ),
        .dout       ( dout       ),
        .dout_ready ( dout_ready )
    );

endmodule

/* verilog/burst_pkg.sv */
package burst_pkg;

    localparam int LEN_W = 8;

    // Accepting edge to first dout_ready beat
    localparam int READ_LATENCY = 8;

    // Zero means no command, 1 to 255 are real bursts
    typedef logic [LEN_W-1:0] len_t;

endpackage

/* verilog/burst_sequencer.sv */
`timescale 1ns/1ps

module burst_sequencer (
    input  logic                clk,
    input  logic                arst_n,
    input  mem_geom_pkg::word_t din,
    input  mem_geom_pkg::be_t   be,
    burst_cmd_if.sequencer      cmd,
    mem_port_if.requester       port
);
    import mem_geom_pkg::*;
    import burst_pkg::*;

    logic                              reading;
    len_t                              cnt;      // Beats still to issue
    addr_t                             addr_q;
    logic [$clog2(READ_LATENCY)-1:0]   lat_cnt;
    logic                              beat;

    // Write beats run straight from the cycle after start
    assign port.wr = cmd.active && !reading;

    // Read beats wait for the latency counter
    assign port.rd = cmd.active && reading && (lat_cnt == '0);

    assign beat = port.rd || port.wr;

    // Write payload comes from the top-level pins unregistered
    assign port.wdata = din;
    assign port.be    = be;
    assign port.addr  = addr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd.active <= 1'b0;
            reading    <= 1'b0;
            cnt        <= '0;
            lat_cnt    <= '0;
        end else if (cmd.start) begin
            cmd.active <= 1'b1;
            reading    <= cmd.is_read;
            cnt        <= cmd.len;
            // One cycle for decode and one for the array read register
            // are taken out of the total read latency
            lat_cnt    <= cmd.is_read ? ($clog2(READ_LATENCY))'(READ_LATENCY - 2) : '0;
        end else if (cmd.active) begin
            if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
            if (beat) begin
                cnt <= cnt - 1'b1;
                if (cnt == len_t'(1)) begin
                    cmd.active <= 1'b0;  // Last beat goes out this cycle
                end
            end
        end
    end

    // Address wraps at MEM_WORDS through the natural overflow of addr_t
    always_ff @(posedge clk) begin
        if (cmd.start) begin
            addr_q <= cmd.base;
        end else if (beat) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    // Every beat is still owed by the burst counter
    a_beat_counted: assert property (
        @(posedge clk) disable iff (!arst_n)
        beat |-> (cnt != '0)
    );

endmodule

/* verilog/mem_geom_pkg.sv */
package mem_geom_pkg;

    // Storage word and its byte lanes
    localparam int DATA_W = 64;
    localparam int LANE_W = 8;
    localparam int LANES = DATA_W / LANE_W;

    // Word addressing, depth follows the address width
    localparam int ADDR_W = 10;
    localparam int MEM_WORDS = 1 << ADDR_W;  // 1024 words

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [LANES-1:0] be_t;  // One enable bit per lane
    typedef logic [ADDR_W-1:0] addr_t;

endpackage
